// ==== logic/an_lane.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Clause 37 negotiation lane
// Restart, ability, ack, idle, link-ok FSM with link timer,
// watchdog abort and config word generation
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module an_lane
   import an_pkg::*;
#(
   parameter int TIMER_TICKS = 10000      // Link timer in ticks
) (
   input  logic       rx_clk,
   input  logic       an_rst,
   input  logic       tick,
   input  logic       los,
   input  lacr_word_t lacr_in,
   input  logic       lacr_in_stb,
   output lacr_word_t lacr_out,
   output logic       lacr_send,
   output logic       operate,
   output an_status_t an_status
);

   localparam int TMR_W      = $clog2(TIMER_TICKS + 1);
   localparam int WDOG_TICKS = 8 * TIMER_TICKS;   // Eight link timers
   localparam int WDOG_W     = $clog2(WDOG_TICKS + 1);
   localparam lacr_word_t ACKED_ABILITY = local_ability | (lacr_word_t'(1'b1) << ack_bit);

   an_state_t         state;
   an_state_t         state_d;
   lacr_word_t        held_word;
   logic              match_ok;
   logic              breaklink_restart;
   logic              link_det;           // Partner words seen since los
   logic              abl_seen;           // Ability word captured
   logic              ack_seen;
   logic              consistent;         // Acked word equals ability word
   lacr_word_t        ability_word;       // Partner ability, ack forced
   logic              abl_capture;
   logic [TMR_W-1:0]  timer_cnt;
   logic              timer_done;
   logic              timer_load;
   logic [WDOG_W-1:0] wdog_cnt;
   logic              wdog_disable;
   logic              wdog_timeout;
   logic              progress;

   lacr_match_detect u_match (
      .rx_clk            (rx_clk),
      .an_rst            (an_rst),
      .restart_hold      (state == an_restart),
      .lacr_in           (lacr_in),
      .lacr_in_stb       (lacr_in_stb),
      .held_word         (held_word),
      .match_ok          (match_ok),
      .breaklink_restart (breaklink_restart)
   );

   always_ff @(posedge rx_clk) begin
      if (an_rst || los)
         link_det <= 1'b0;
      else if (lacr_in_stb)
         link_det <= 1'b1;
   end

   assign abl_capture = (state == an_ability) && match_ok && !held_word[ack_bit];

   // Ability capture and ack flags, cleared in restart
   always_ff @(posedge rx_clk) begin
      if (abl_capture) begin
         ability_word          <= held_word;
         ability_word[ack_bit] <= 1'b1;   // Compared against acked version
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst || state == an_restart) begin
         abl_seen   <= 1'b0;
         ack_seen   <= 1'b0;
         consistent <= 1'b0;
      end else begin
         if (abl_capture)
            abl_seen <= 1'b1;
         if (state == an_ack && match_ok && held_word[ack_bit]) begin
            ack_seen   <= 1'b1;
            consistent <= (held_word == ability_word);
         end else if (state == an_ack && ack_seen) begin
            consistent <= (held_word == ability_word);
         end
      end
   end

   // Next state
   always_comb begin
      state_d = state;
      case (state)
         an_restart: if (timer_done && link_det)
                        state_d = wdog_disable ? an_abort : an_ability;
         an_ability: if (abl_capture)
                        state_d = an_ack;
         an_ack:     if (timer_done && ack_seen)
                        state_d = consistent ? an_idle : an_restart;
         an_idle:    if (timer_done)
                        state_d = an_link_ok;   // No idle marker check
         an_link_ok,
         an_abort:   state_d = state;
         default:    state_d = an_restart;
      endcase
      if (los || (breaklink_restart && !wdog_disable) || wdog_timeout)
         state_d = an_restart;
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst)
         state <= an_restart;
      else
         state <= state_d;
   end

   // Link timer, reloaded on entry to a timed state
   assign timer_load = (state_d != state) &&
                       (state_d == an_restart || state_d == an_ack || state_d == an_idle);
   assign timer_done = (timer_cnt == '0);

   always_ff @(posedge rx_clk) begin
      if (an_rst || timer_load)
         timer_cnt <= TMR_W'(TIMER_TICKS);
      else if (tick && !timer_done)
         timer_cnt <= timer_cnt - 1'b1;
   end

   // Watchdog over stalled negotiation
   assign progress     = (state_d > state) && (state != an_restart);
   assign wdog_timeout = (wdog_cnt == WDOG_W'(WDOG_TICKS));

   always_ff @(posedge rx_clk) begin
      if (an_rst || progress || los) begin
         wdog_cnt     <= '0;
         wdog_disable <= 1'b0;
      end else if (wdog_timeout) begin
         wdog_cnt     <= '0;
         wdog_disable <= 1'b1;            // Next pass ends in abort
      end else if (link_det && state != an_link_ok && !wdog_disable && tick) begin
         wdog_cnt <= wdog_cnt + 1'b1;
      end
   end

   // Registered outputs, one cycle behind state
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_out  <= '0;                 // Break link
         lacr_send <= 1'b1;
         operate   <= 1'b0;
         an_status <= '0;
      end else begin
         lacr_send <= (state == an_restart) || (state == an_ability) || (state == an_ack);
         operate   <= (state == an_link_ok) || (state == an_abort);
         case (state)
            an_ability:     lacr_out <= local_ability;
            an_ack, an_idle: lacr_out <= ACKED_ABILITY;   // Idle keeps acked word
            default:        lacr_out <= '0;
         endcase
         an_status <= {wdog_disable, held_word[rf2_bit], held_word[rf1_bit],
                       abl_seen && !ability_word[fd_bit],
                       state == an_ack, state == an_idle, state == an_link_ok};
      end
   end

   // Operate only after a finished idle wait or a watchdog abort
   a_operate_state: assert property (@(posedge rx_clk) disable iff (an_rst)
      $rose(operate) |-> $past(state == an_idle || (state == an_restart && wdog_disable), 2))
      else $error("operate rose without idle or watchdog abort");

   a_state_legal: assert property (@(posedge rx_clk) disable iff (an_rst)
      state inside {an_restart, an_ability, an_ack, an_idle, an_link_ok, an_abort})
      else $error("illegal lane state");

endmodule

// ==== logic/an_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Clause 37 auto-negotiation shared types
// Config word fields, lane status layout, lane FSM states
// ~~~~~~~~~~~~~~~~~~~~
package an_pkg;

   // 16-bit config register word as carried in /C/ ordered sets
   typedef logic [15:0] lacr_word_t;

   // Lane status, top bit down:
   // wdog disable, rf2, rf1, ability mismatch, in ack, in idle, link ok
   typedef logic [6:0] an_status_t;

   // Lane negotiation states
   typedef enum logic [2:0] {
      an_restart = 3'd0,   // Break link, link timer
      an_ability = 3'd1,   // Ability detect
      an_ack     = 3'd2,   // Ack detect and complete ack
      an_idle    = 3'd3,   // Idle, waits out one timer
      an_link_ok = 3'd4,   // Upper layers on
      an_abort   = 3'd5    // Negotiation given up
   } an_state_t;

   // Config word bit positions
   localparam int np_bit  = 15;   // Next page
   localparam int ack_bit = 14;   // Acknowledge
   localparam int rf2_bit = 13;   // Remote fault 2
   localparam int rf1_bit = 12;   // Remote fault 1
   localparam int ps2_bit = 8;    // Asym pause
   localparam int ps1_bit = 7;    // Sym pause
   localparam int hd_bit  = 6;    // Half duplex
   localparam int fd_bit  = 5;    // Full duplex

   // Local advertised abilities, reserved bits zero
   localparam lacr_word_t local_ability =
        (lacr_word_t'(1'b1) << fd_bit)    // Full duplex only
      | (lacr_word_t'(1'b0) << hd_bit)    // No half duplex
      | (lacr_word_t'(1'b0) << ps1_bit)   // No pause
      | (lacr_word_t'(1'b0) << ps2_bit)
      | (lacr_word_t'(1'b0) << rf1_bit)   // Remote fault never sent
      | (lacr_word_t'(1'b0) << rf2_bit)
      | (lacr_word_t'(1'b0) << np_bit);   // No next pages

endpackage

// ==== logic/an_status_collect.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Lane status collector
// Registered count of operating lanes and all-up flag
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module an_status_collect #(
   parameter int NUM_LANES = 4
) (
   input  logic                               rx_clk,
   input  logic                               an_rst,
   input  logic [NUM_LANES-1:0]               operate_in,   // Lane 0 in bit 0
   output logic [$clog2(NUM_LANES+1)-1:0]     lanes_up,
   output logic                               all_up
);

   localparam int CNT_W = $clog2(NUM_LANES + 1);

   logic [CNT_W-1:0] up_cnt;              // Combinational lane count

   // Population count over operate
   always_comb begin
      up_cnt = '0;
      for (int i = 0; i < NUM_LANES; i++) begin
         up_cnt = up_cnt + CNT_W'(operate_in[i]);
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lanes_up <= '0;
         all_up   <= 1'b0;
      end else begin
         lanes_up <= up_cnt;
         all_up   <= &operate_in;         // Every lane running
      end
   end

   // Summary outputs agree with each other
   a_all_up_count: assert property (@(posedge rx_clk) disable iff (an_rst)
      all_up |-> (lanes_up == CNT_W'(NUM_LANES)))
      else $error("all_up without full lane count");

endmodule

// ==== logic/an_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Multi-lane 1000BASE-X auto-negotiation
// Shared tick, per-lane negotiation, status summary
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module an_top
   import an_pkg::*;
#(
   parameter int NUM_LANES   = 4,
   parameter int TICK_DIV    = 125,       // rx_clk cycles per tick
   parameter int TIMER_TICKS = 10000      // 10 ms link timer
) (
   input  logic                            rx_clk,
   input  logic                            an_rst,
   input  logic       [NUM_LANES-1:0]      los,
   input  lacr_word_t [NUM_LANES-1:0]      lacr_in,
   input  logic       [NUM_LANES-1:0]      lacr_in_stb,
   output lacr_word_t [NUM_LANES-1:0]      lacr_out,
   output logic       [NUM_LANES-1:0]      lacr_send,
   output logic       [NUM_LANES-1:0]      operate,
   output an_status_t [NUM_LANES-1:0]      an_status,
   output logic [$clog2(NUM_LANES+1)-1:0]  lanes_up,
   output logic                            all_up
);

   logic tick;                            // Shared timer strobe

   link_tick_gen #(.TICK_DIV(TICK_DIV)) u_tick (
      .rx_clk (rx_clk),
      .an_rst (an_rst),
      .tick   (tick)
   );

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      an_lane #(.TIMER_TICKS(TIMER_TICKS)) u_lane (
         .rx_clk      (rx_clk),
         .an_rst      (an_rst),
         .tick        (tick),
         .los         (los[i]),
         .lacr_in     (lacr_in[i]),
         .lacr_in_stb (lacr_in_stb[i]),
         .lacr_out    (lacr_out[i]),
         .lacr_send   (lacr_send[i]),
         .operate     (operate[i]),
         .an_status   (an_status[i])
      );
   end

   an_status_collect #(.NUM_LANES(NUM_LANES)) u_collect (
      .rx_clk     (rx_clk),
      .an_rst     (an_rst),
      .operate_in (operate),
      .lanes_up   (lanes_up),
      .all_up     (all_up)
   );

endmodule

// ==== logic/lacr_match_detect.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Received config word filter
// Three identical words in a row give match_ok,
// three break-link words give breaklink_restart
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lacr_match_detect
   import an_pkg::*;
(
   input  logic       rx_clk,
   input  logic       an_rst,
   input  logic       restart_hold,       // Lane in an_restart
   input  lacr_word_t lacr_in,
   input  logic       lacr_in_stb,
   output lacr_word_t held_word,          // Last strobed word
   output logic       match_ok,
   output logic       breaklink_restart
);

   localparam logic [2:0] RUN_LEN = 3'd3; // Identical words needed

   logic       same_q;                    // Word equal to previous
   logic       diff_q;                    // Word differs from previous
   logic [2:0] run_cnt;                   // Identical words in current run
   logic [1:0] zero_cnt;                  // Consecutive break-link words

   // Previous word and compare flags, frozen in restart
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         held_word <= '0;                 // Compare baseline
         same_q    <= 1'b0;
         diff_q    <= 1'b0;
      end else if (restart_hold) begin
         same_q <= 1'b0;
         diff_q <= 1'b0;
      end else begin
         if (lacr_in_stb)
            held_word <= lacr_in;
         same_q <= lacr_in_stb && (lacr_in == held_word);
         diff_q <= lacr_in_stb && (lacr_in != held_word);
      end
   end

   assign match_ok = (run_cnt == RUN_LEN);

   // Run counter, one pulse per three words
   always_ff @(posedge rx_clk) begin
      if (an_rst || restart_hold || breaklink_restart)
         run_cnt <= '0;
      else if (diff_q)
         run_cnt <= 3'd1;                 // New word opens a run
      else if (match_ok)
         run_cnt <= '0;
      else if (same_q)
         run_cnt <= run_cnt + 3'd1;
   end

   // Break-link detect, runs in every state
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         zero_cnt          <= '0;
         breaklink_restart <= 1'b0;
      end else begin
         breaklink_restart <= 1'b0;
         if (lacr_in_stb) begin
            if (lacr_in == '0) begin
               if (zero_cnt == 2'd2) begin
                  zero_cnt          <= '0;   // Third zero word
                  breaklink_restart <= 1'b1;
               end else begin
                  zero_cnt <= zero_cnt + 2'd1;
               end
            end else begin
               zero_cnt <= '0;
            end
         end
      end
   end

   // Run count bounded and never overlapping a break-link restart
   a_run_bound: assert property (@(posedge rx_clk) disable iff (an_rst)
      !(match_ok && breaklink_restart) && (run_cnt <= RUN_LEN))
      else $error("match run overrun or match with break-link");

endmodule

// ==== logic/link_tick_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Link timer prescaler
// One-cycle tick every TICK_DIV clocks, shared by all lanes
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module link_tick_gen #(
   parameter int TICK_DIV = 125           // 1 us at 125 MHz
) (
   input  logic rx_clk,
   input  logic an_rst,
   output logic tick
);

   localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;             // Free-running phase

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         div_cnt <= '0;
         tick    <= 1'b0;
      end else if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
         div_cnt <= '0;                   // Wrap
         tick    <= 1'b1;
      end else begin
         div_cnt <= div_cnt + 1'b1;
         tick    <= 1'b0;
      end
   end

   // Lanes count ticks as single events
   a_tick_single: assert property (@(posedge rx_clk) disable iff (an_rst)
      tick |=> !tick)
      else $error("tick high on two consecutive cycles");

endmodule

// ==== project.f ====
logic/an_pkg.sv
logic/link_tick_gen.sv
logic/lacr_match_detect.sv
logic/an_lane.sv
logic/an_status_collect.sv
logic/an_top.sv
testbench/tb_an_top.sv

// ==== testbench/tb_an_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the four-lane auto-negotiation top
// Partner model, reference check of lane outputs,
// restart, inconsistency and watchdog cases
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_an_top
   import an_pkg::*;
();

   localparam int NUM_LANES = 4;
   localparam int WAIT_MAX  = 2000;       // Cycles per bounded wait

   // Bit positions in the lane view {operate, an_status}
   localparam int view_link_ok  = 0;
   localparam int view_ack      = 2;
   localparam int view_mismatch = 3;
   localparam int view_wdog     = 6;
   localparam int view_operate  = 7;

   localparam lacr_word_t acked_word = local_ability | (lacr_word_t'(1'b1) << ack_bit);

   logic                        rx_clk;
   logic                        an_rst;
   logic       [NUM_LANES-1:0]  los;
   lacr_word_t [NUM_LANES-1:0]  lacr_in;
   logic       [NUM_LANES-1:0]  lacr_in_stb;
   lacr_word_t [NUM_LANES-1:0]  lacr_out;
   logic       [NUM_LANES-1:0]  lacr_send;
   logic       [NUM_LANES-1:0]  operate;
   an_status_t [NUM_LANES-1:0]  an_status;
   logic       [2:0]            lanes_up;
   logic                        all_up;

   logic [NUM_LANES-1:0] guard;           // Lanes that must keep operate low
   logic [NUM_LANES-1:0] prev_operate;    // Operate one cycle back
   integer               seed;

   an_top #(.NUM_LANES(NUM_LANES), .TICK_DIV(4), .TIMER_TICKS(8)) dut (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .lacr_out    (lacr_out),
      .lacr_send   (lacr_send),
      .operate     (operate),
      .an_status   (an_status),
      .lanes_up    (lanes_up),
      .all_up      (all_up)
   );

   initial rx_clk = 1'b0;
   always #4 rx_clk = ~rx_clk;            // 8 ns period

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("TB FAILED");
         $fatal(1, "stopped on first mismatch");
      end
   endtask

   function automatic logic [7:0] lane_view(input int lane);
      return {operate[lane], an_status[lane]};
   endfunction

   // Lane state as seen from its status and outputs
   function automatic an_state_t decode_state(input an_status_t st, input logic op,
                                              input lacr_word_t word);
      if (st[0])
         return an_link_ok;
      if (st[1])
         return an_idle;
      if (st[2])
         return an_ack;
      if (st[6] && op)
         return an_abort;                 // Disabled and running
      if (!st[6] && word != '0)
         return an_ability;
      return an_restart;
   endfunction

   // Expected {lacr_out, lacr_send} per state
   function automatic logic [16:0] expect_word(input an_state_t s);
      case (s)
         an_restart: return {16'h0000, 1'b1};        // Break link
         an_ability: return {local_ability, 1'b1};
         an_ack:     return {acked_word, 1'b1};
         an_idle:    return {acked_word, 1'b0};      // Acked word kept, no send
         default:    return {16'h0000, 1'b0};        // Link ok and abort
      endcase
   endfunction

   task automatic check_restart(input int lane);
      check_value($sformatf("operate[%0d]", lane), operate[lane], 0);
      check_value($sformatf("lacr_send[%0d]", lane), lacr_send[lane], 1);
      check_value($sformatf("lacr_out[%0d]", lane), lacr_out[lane], 0);
   endtask

   // Partner strobes one word every 4 cycles until a view bit reaches level
   task send_until(input int lane, input lacr_word_t word, input int pos,
                   input logic level, input string what);
      logic       done;
      logic [7:0] view;
      int         cyc;
      done = 1'b0;
      cyc  = 0;
      while (!done && cyc < WAIT_MAX) begin
         @(posedge rx_clk);
         lacr_in[lane]     <= word;
         lacr_in_stb[lane] <= (cyc % 4 == 0);
         @(negedge rx_clk);
         view = lane_view(lane);          // Outputs settled at falling edge
         done = (view[pos] === level);
         cyc++;
      end
      @(posedge rx_clk);
      lacr_in_stb[lane] <= 1'b0;
      if (!done) begin
         $display("Timeout: lane %0d did not %s within %0d cycles", lane, what, WAIT_MAX);
         $display("TB FAILED");
         $fatal(1, "wait timed out");
      end
   endtask

   // Ability words until ack, then the same word with ack set
   task negotiate(input int lane, input lacr_word_t abl_word);
      send_until(lane, abl_word, view_ack, 1'b1, "enter ack");
      send_until(lane, abl_word | (lacr_word_t'(1'b1) << ack_bit), view_link_ok, 1'b1,
                 "reach link ok");
   endtask

   task drop_link(input logic [NUM_LANES-1:0] mask);
      @(posedge rx_clk);
      los <= mask;
      repeat (3) @(posedge rx_clk);       // State then registered outputs
      los <= '0;
      @(negedge rx_clk);
      for (int i = 0; i < NUM_LANES; i++)
         if (mask[i])
            check_restart(i);
   endtask

   // Every lane against the reference, every cycle
   always @(negedge rx_clk) begin : compare_outputs
      an_state_t   st;
      logic [16:0] exp;
      if (!an_rst) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            st  = decode_state(an_status[i], operate[i], lacr_out[i]);
            exp = expect_word(st);
            check_value($sformatf("lacr_out[%0d]", i), lacr_out[i], exp[16:1]);
            check_value($sformatf("lacr_send[%0d]", i), lacr_send[i], exp[0]);
            check_value($sformatf("operate[%0d]", i), operate[i],
                        (st == an_link_ok) || (st == an_abort));
            if (guard[i])
               check_value($sformatf("operate[%0d] guarded", i), operate[i], 0);
         end
         check_value("lanes_up", lanes_up, $countones(prev_operate));   // One cycle behind
         check_value("all_up", all_up, &prev_operate);
      end
      prev_operate = operate;
   end

   initial begin : main
      lacr_word_t rnd_word;
      integer     rnd;
      seed        = 28;
      an_rst      = 1'b1;
      los         = '0;
      lacr_in     = '0;
      lacr_in_stb = '0;
      guard       = '0;
      repeat (4) @(posedge rx_clk);
      an_rst <= 1'b0;
      @(negedge rx_clk);

      // Reset values on every lane
      for (int i = 0; i < NUM_LANES; i++)
         check_restart(i);
      check_value("lanes_up", lanes_up, 0);

      // Lane 0 alone
      negotiate(0, 16'h0020);
      check_value("an_status[0] mismatch", an_status[0][view_mismatch], 0);
      check_value("operate[0]", operate[0], 1);
      check_value("operate[3:1]", operate[3:1], 0);   // Silent lanes stay down

      // All lanes with random consistent extras, full duplex always set
      drop_link(4'hF);
      for (int i = 0; i < NUM_LANES; i++) begin
         rnd      = $random(seed);
         rnd_word = (lacr_word_t'(rnd) & 16'h31C0) | (lacr_word_t'(1'b1) << fd_bit);
         negotiate(i, rnd_word);
         repeat (2) @(negedge rx_clk);
         check_value($sformatf("an_status[%0d] mismatch", i),
                     an_status[i][view_mismatch], 0);
         check_value($sformatf("an_status[%0d] remote fault", i), an_status[i][5:4],
                     {rnd_word[rf2_bit], rnd_word[rf1_bit]});   // Partner fault bits
         check_value("lanes_up", lanes_up, i + 1);
      end
      check_value("all_up", all_up, 1);

      // Half duplex only partner on lane 1
      drop_link(4'b0010);
      negotiate(1, 16'h0040);
      check_value("an_status[1] mismatch", an_status[1][view_mismatch], 1);

      // Restart by los on lane 2, by break-link words on lane 3
      drop_link(4'b0100);
      send_until(3, 16'h0000, view_link_ok, 1'b0, "leave link ok on break link");
      check_restart(3);

      // Partner never acks, lane 3 gives up and runs
      send_until(3, 16'h0020, view_wdog, 1'b1, "latch watchdog disable");
      send_until(3, 16'h0020, view_operate, 1'b1, "enter abort");
      check_value("lacr_send[3]", lacr_send[3], 0);
      check_value("lacr_out[3]", lacr_out[3], 0);

      // Ack word disagrees with ability word on lane 2
      guard[2] = 1'b1;
      send_until(2, 16'h0020, view_ack, 1'b1, "enter ack");
      send_until(2, 16'h4060, view_ack, 1'b0, "leave ack");
      check_value("an_status[2] idle", an_status[2][1], 0);
      check_restart(2);
      drop_link(4'b0100);                 // Park lane 2 without link
      guard[2] = 1'b0;

      repeat (2) @(negedge rx_clk);
      check_value("lanes_up", lanes_up, 3);
      check_value("all_up", all_up, 0);
      $display("TB PASSED");
      $finish;
   end

endmodule
